// ==== common/ex_defines.svh ====
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// ****************************************
// Execute stage field widths
// ****************************************

`define EX_WORD_W 32 // Data word, PC and branch target
`define EX_REG_W  5
`define EX_SA_W   5  // Shift amount field of R-type shifts
`define EX_IMM_W  16
`define EX_JIDX_W 26 // Instruction index of J and JAL

`endif

// ==== common/ex_types_pkg.sv ====
`default_nettype none

`include "ex_defines.svh"

package ex_types_pkg;

    // ****************************************
    // Vector types with a meaning of their own
    // ****************************************

    typedef logic [`EX_WORD_W-1:0] word_t;

    typedef logic [`EX_REG_W-1:0] reg_addr_t; // Register number in the register file

    typedef logic [`EX_SA_W-1:0] shamt_t;

    // Raw immediate as it sits in the instruction word
    typedef logic [`EX_IMM_W-1:0] imm_t;

    typedef logic [`EX_JIDX_W-1:0] jidx_t;

endpackage

`default_nettype wire

// ==== common/ex_ctrl_pkg.sv ====
`default_nettype none

package ex_ctrl_pkg;

    // ****************************************
    // Decoded control encodings
    // ****************************************

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

    typedef enum logic {
        SRC_B_RT  = 1'b0, // Second register operand
        SRC_B_IMM = 1'b1  // Extended immediate
    } src_b_e;

    // BR_NONE is the value a bubble carries
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,
        BR_BNE  = 4'd2,
        BR_BLEZ = 4'd3,
        BR_BGTZ = 4'd4,
        BR_BLTZ = 4'd5,
        BR_BGEZ = 4'd6,
        BR_J    = 4'd7,
        BR_JR   = 4'd8
    } br_cond_e;

endpackage

`default_nettype wire

// ==== common/id_ex_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface id_ex_if import ex_types_pkg::*, ex_ctrl_pkg::*; (
    input wire clk,
    input wire rst_n_i
);
    logic      valid;

    word_t     pc;
    word_t     rs_data;
    word_t     rt_data;
    word_t     ext_imm; // Already sign or zero extended by decode
    shamt_t    sa;
    jidx_t     j_idx;

    alu_op_e   alu_op;
    src_b_e    src_b;
    logic      check_ov;

    br_cond_e  br_cond;
    logic      link; // Write pc+8 instead of the ALU result

    logic      wr_en;
    reg_addr_t wr_dst;

    // Written by the pipeline register
    modport src (
        input  clk, rst_n_i,
        output valid, pc, rs_data, rt_data, ext_imm, sa, j_idx,
        output alu_op, src_b, check_ov, br_cond, link, wr_en, wr_dst
    );

    // ALU side, also taken by the result merge for writeback control
    modport alu (
        input clk, rst_n_i,
        input valid, rs_data, rt_data, ext_imm, sa,
        input alu_op, src_b, check_ov, link, wr_en, wr_dst
    );

    modport br (
        input clk, rst_n_i,
        input valid, pc, rs_data, rt_data, ext_imm, j_idx, br_cond
    );

endinterface

`default_nettype wire

// ==== verilog/id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg import ex_types_pkg::*, ex_ctrl_pkg::*; (
    input  wire       clk,
    input  wire       rst_n_i,
    input  wire       stall_i,
    input  wire       flush_i,
    input  wire       exception_flush_i,

    input  wire       in_valid_i,
    input  wire word_t     in_pc_i,
    input  wire word_t     in_rs_data_i,
    input  wire word_t     in_rt_data_i,
    input  wire word_t     in_ext_imm_i,
    input  wire shamt_t    in_sa_i,
    input  wire jidx_t     in_j_idx_i,
    input  wire alu_op_e   in_alu_op_i,
    input  wire src_b_e    in_src_b_i,
    input  wire            in_check_ov_i,
    input  wire br_cond_e  in_br_cond_i,
    input  wire            in_link_i,
    input  wire            in_wr_en_i,
    input  wire reg_addr_t in_wr_dst_i,

    id_ex_if.src ex_o
);
    logic clear;

    // A plain flush loses against a stall, an exception flush does not
    assign clear = exception_flush_i | (flush_i & ~stall_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i || clear) begin
            ex_o.valid    <= 1'b0;
            ex_o.pc       <= '0;
            ex_o.rs_data  <= '0;
            ex_o.rt_data  <= '0;
            ex_o.ext_imm  <= '0;
            ex_o.sa       <= '0;
            ex_o.j_idx    <= '0;
            ex_o.alu_op   <= ALU_ADD;
            ex_o.src_b    <= SRC_B_RT;
            ex_o.check_ov <= 1'b0;
            ex_o.br_cond  <= BR_NONE;
            ex_o.link     <= 1'b0;
            ex_o.wr_en    <= 1'b0;
            ex_o.wr_dst   <= '0;
        end else if (!stall_i) begin
            ex_o.valid    <= in_valid_i;
            ex_o.pc       <= in_pc_i;
            ex_o.rs_data  <= in_rs_data_i;
            ex_o.rt_data  <= in_rt_data_i;
            ex_o.ext_imm  <= in_ext_imm_i;
            ex_o.sa       <= in_sa_i;
            ex_o.j_idx    <= in_j_idx_i;
            ex_o.alu_op   <= in_alu_op_i;
            ex_o.src_b    <= in_src_b_i;
            ex_o.check_ov <= in_check_ov_i;
            ex_o.br_cond  <= in_br_cond_i;
            ex_o.link     <= in_link_i;
            ex_o.wr_en    <= in_wr_en_i;
            ex_o.wr_dst   <= in_wr_dst_i;
        end
    end

    // ****************************************
    // Checks
    // ****************************************

    a_exc_flush_bubble: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        exception_flush_i |=> !ex_o.valid
    );

endmodule

`default_nettype wire

// ==== alu/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_alu import ex_types_pkg::*, ex_ctrl_pkg::*; (
    id_ex_if.alu ex_i,
    output word_t alu_result_o,
    output logic  alu_ov_o
);
    word_t op_a;
    word_t op_b;
    word_t sum;
    word_t diff;
    imm_t  lui_imm;

    assign op_a    = ex_i.rs_data;
    assign op_b    = (ex_i.src_b == SRC_B_IMM) ? ex_i.ext_imm : ex_i.rt_data;
    assign sum     = op_a + op_b;
    assign diff    = op_a - op_b;
    assign lui_imm = ex_i.ext_imm[`EX_IMM_W-1:0];

    always_comb begin
        alu_result_o = '0;
        alu_ov_o     = 1'b0;
        case (ex_i.alu_op)
            ALU_ADD: begin
                alu_result_o = sum;
                // Same operand signs but the sum sign differs
                alu_ov_o = (op_a[`EX_WORD_W-1] == op_b[`EX_WORD_W-1]) &&
                           (sum[`EX_WORD_W-1] != op_a[`EX_WORD_W-1]);
            end
            ALU_SUB: begin
                alu_result_o = diff;
                alu_ov_o = (op_a[`EX_WORD_W-1] != op_b[`EX_WORD_W-1]) &&
                           (diff[`EX_WORD_W-1] != op_a[`EX_WORD_W-1]);
            end
            ALU_AND:  alu_result_o = op_a & op_b;
            ALU_OR:   alu_result_o = op_a | op_b;
            ALU_XOR:  alu_result_o = op_a ^ op_b;
            ALU_NOR:  alu_result_o = ~(op_a | op_b);
            ALU_SLT:  alu_result_o = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_result_o = word_t'(op_a < op_b);
            // Shifts always work on rt, whatever the operand B source is
            ALU_SLL:  alu_result_o = ex_i.rt_data << ex_i.sa;
            ALU_SRL:  alu_result_o = ex_i.rt_data >> ex_i.sa;
            ALU_SRA:  alu_result_o = word_t'($signed(ex_i.rt_data) >>> ex_i.sa);
            ALU_LUI:  alu_result_o = {lui_imm, {(`EX_WORD_W-`EX_IMM_W){1'b0}}};
            default: begin
                alu_result_o = '0;
                alu_ov_o     = 1'b0;
            end
        endcase
    end

    // ****************************************
    // Checks
    // ****************************************

    a_no_ov_logic_shift: assert property (
        @(posedge ex_i.clk) disable iff (!ex_i.rst_n_i)
        (ex_i.alu_op inside {ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
                             ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI}) |-> !alu_ov_o
    );

endmodule

`default_nettype wire

// ==== branch/ex_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_branch_unit import ex_types_pkg::*, ex_ctrl_pkg::*; (
    id_ex_if.br   ex_i,
    output logic  br_taken_o,
    output word_t br_target_o,
    output word_t link_addr_o
);
    word_t pc_plus4;
    word_t br_offset;
    word_t cond_target;
    word_t jump_target;
    logic  rs_neg;
    logic  rs_zero;
    logic  cond_met;

    assign pc_plus4    = ex_i.pc + word_t'(4);
    assign link_addr_o = ex_i.pc + word_t'(8); // Return past the delay slot

    assign br_offset   = {ex_i.ext_imm[`EX_WORD_W-3:0], 2'b00};
    assign cond_target = pc_plus4 + br_offset;
    // Stays inside the 256 MB region of the delay slot
    assign jump_target = {pc_plus4[`EX_WORD_W-1:`EX_JIDX_W+2], ex_i.j_idx, 2'b00};

    assign rs_neg  = ex_i.rs_data[`EX_WORD_W-1];
    assign rs_zero = (ex_i.rs_data == '0);

    always_comb begin
        cond_met    = 1'b0;
        br_target_o = cond_target;
        case (ex_i.br_cond)
            BR_BEQ:  cond_met = (ex_i.rs_data == ex_i.rt_data);
            BR_BNE:  cond_met = (ex_i.rs_data != ex_i.rt_data);
            BR_BLEZ: cond_met = rs_neg | rs_zero;
            BR_BGTZ: cond_met = ~rs_neg & ~rs_zero;
            BR_BLTZ: cond_met = rs_neg;
            BR_BGEZ: cond_met = ~rs_neg;
            BR_J: begin
                cond_met    = 1'b1;
                br_target_o = jump_target;
            end
            BR_JR: begin
                cond_met    = 1'b1;
                br_target_o = ex_i.rs_data;
            end
            default: cond_met = 1'b0;
        endcase
    end

    assign br_taken_o = ex_i.valid & cond_met;

    // ****************************************
    // Checks
    // ****************************************

    a_no_taken_bubble: assert property (
        @(posedge ex_i.clk) disable iff (!ex_i.rst_n_i)
        !ex_i.valid |-> !br_taken_o
    );

endmodule

`default_nettype wire

// ==== verilog/ex_result_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_result_merge import ex_types_pkg::*; (
    input  wire         clk,
    input  wire         rst_n_i,
    input  wire         stall_i,
    input  wire         exception_flush_i,

    id_ex_if.alu        ex_i,
    input  wire word_t  alu_result_i,
    input  wire         alu_ov_i,
    input  wire         br_taken_i,
    input  wire word_t  br_target_i,
    input  wire word_t  link_addr_i,

    output logic        out_valid_o,
    output logic        out_wr_en_o,
    output reg_addr_t   out_wr_dst_o,
    output word_t       out_result_o,
    output logic        redirect_o,
    output word_t       redirect_target_o,
    output logic        exc_ov_o
);
    logic ov_trap;

    // Overflow only traps for the add and subtract forms that ask for it
    assign ov_trap = ex_i.valid & ex_i.check_ov & alu_ov_i;

    // ****************************************
    // Control state
    // ****************************************

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
            out_wr_en_o <= 1'b0;
            redirect_o  <= 1'b0;
            exc_ov_o    <= 1'b0;
        end else if (exception_flush_i) begin
            out_valid_o <= 1'b0;
            out_wr_en_o <= 1'b0;
            redirect_o  <= 1'b0;
            exc_ov_o    <= 1'b0;
        end else if (!stall_i) begin
            out_valid_o <= ex_i.valid;
            out_wr_en_o <= ex_i.valid & ex_i.wr_en & ~ov_trap; // Trapped result is dropped
            redirect_o  <= ex_i.valid & br_taken_i;
            exc_ov_o    <= ov_trap;
        end
    end

    // ****************************************
    // Payload
    // ****************************************

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            out_wr_dst_o      <= ex_i.wr_dst;
            out_result_o      <= ex_i.link ? link_addr_i : alu_result_i;
            redirect_target_o <= br_target_i;
        end
    end

    a_no_write_on_trap: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(exc_ov_o && out_wr_en_o)
    );

endmodule

`default_nettype wire

// ==== verilog/ex_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage_top import ex_types_pkg::*, ex_ctrl_pkg::*; (
    input  wire            clk,
    input  wire            rst_n_i,
    input  wire            stall_i,
    input  wire            flush_i,
    input  wire            exception_flush_i,

    input  wire            in_valid_i,
    input  wire word_t     in_pc_i,
    input  wire word_t     in_rs_data_i,
    input  wire word_t     in_rt_data_i,
    input  wire word_t     in_ext_imm_i,
    input  wire shamt_t    in_sa_i,
    input  wire jidx_t     in_j_idx_i,
    input  wire alu_op_e   in_alu_op_i,
    input  wire src_b_e    in_src_b_i,
    input  wire            in_check_ov_i,
    input  wire br_cond_e  in_br_cond_i,
    input  wire            in_link_i,
    input  wire            in_wr_en_i,
    input  wire reg_addr_t in_wr_dst_i,

    output wire            out_valid_o,
    output wire            out_wr_en_o,
    output wire reg_addr_t out_wr_dst_o,
    output wire word_t     out_result_o,
    output wire            redirect_o,
    output wire word_t     redirect_target_o,
    output wire            exc_ov_o
);
    word_t alu_result;
    logic  alu_ov;
    logic  br_taken;
    word_t br_target;
    word_t link_addr;

    id_ex_if ex_if (
        .clk     (clk),
        .rst_n_i (rst_n_i)
    );

    id_ex_reg id_ex_reg_i (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .flush_i           (flush_i),
        .exception_flush_i (exception_flush_i),
        .in_valid_i        (in_valid_i),
        .in_pc_i           (in_pc_i),
        .in_rs_data_i      (in_rs_data_i),
        .in_rt_data_i      (in_rt_data_i),
        .in_ext_imm_i      (in_ext_imm_i),
        .in_sa_i           (in_sa_i),
        .in_j_idx_i        (in_j_idx_i),
        .in_alu_op_i       (in_alu_op_i),
        .in_src_b_i        (in_src_b_i),
        .in_check_ov_i     (in_check_ov_i),
        .in_br_cond_i      (in_br_cond_i),
        .in_link_i         (in_link_i),
        .in_wr_en_i        (in_wr_en_i),
        .in_wr_dst_i       (in_wr_dst_i),
        .ex_o              (ex_if.src)
    );

    // ALU and branch resolver see the same registered instruction
    ex_alu ex_alu_i (
        .ex_i         (ex_if.alu),
        .alu_result_o (alu_result),
        .alu_ov_o     (alu_ov)
    );

    ex_branch_unit ex_branch_unit_i (
        .ex_i        (ex_if.br),
        .br_taken_o  (br_taken),
        .br_target_o (br_target),
        .link_addr_o (link_addr)
    );

    ex_result_merge ex_result_merge_i (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .exception_flush_i (exception_flush_i),
        .ex_i              (ex_if.alu),
        .alu_result_i      (alu_result),
        .alu_ov_i          (alu_ov),
        .br_taken_i        (br_taken),
        .br_target_i       (br_target),
        .link_addr_i       (link_addr),
        .out_valid_o       (out_valid_o),
        .out_wr_en_o       (out_wr_en_o),
        .out_wr_dst_o      (out_wr_dst_o),
        .out_result_o      (out_result_o),
        .redirect_o        (redirect_o),
        .redirect_target_o (redirect_target_o),
        .exc_ov_o          (exc_ov_o)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RST_CYCLES     = 8
) (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1; // Released away from the rising edge
    end

endmodule

`default_nettype wire

// ==== verif/tb_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage import ex_types_pkg::*, ex_ctrl_pkg::*; ();

    localparam int RST_CYCLES  = 8;
    localparam int T1_CYC      = 4;
    localparam int T2_CYC      = 300;
    localparam int T3_CYC      = 300;
    localparam int T4_CYC      = 64;
    localparam int T5_CYC      = 300;
    localparam int T6_CYC      = 300;
    localparam int DRAIN_CYC   = 3;
    localparam int CYCLE_LIMIT = RST_CYCLES + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC
                                 + T6_CYC + 5 * DRAIN_CYC + 50;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     rs;
        word_t     rt;
        word_t     imm;
        shamt_t    sa;
        jidx_t     jidx;
        alu_op_e   op;
        src_b_e    srcb;
        logic      chk;
        br_cond_e  br;
        logic      link;
        logic      wr_en;
        reg_addr_t dst;
    } instr_t;

    logic      clk;
    logic      rst_n;
    logic      stall;
    logic      flush;
    logic      exc_flush;
    instr_t    drv;

    logic      out_valid;
    logic      out_wr_en;
    reg_addr_t out_wr_dst;
    word_t     out_result;
    logic      redirect;
    word_t     redirect_target;
    logic      exc_ov;

    // Model of the two pipeline registers
    instr_t    s1;
    logic      exp_valid;
    logic      exp_wr_en;
    logic      exp_redirect;
    logic      exp_exc;
    reg_addr_t exp_dst;
    word_t     exp_result;
    word_t     exp_target;

    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          test_errs;
    int          tests_run;
    int          issued;
    int          retired;
    int          cycle_cnt;
    logic        edge_stall;

    tb_clkgen #(.HALF_PERIOD_NS(4), .RST_CYCLES(RST_CYCLES)) clkgen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ex_stage_top dut_i (
        .clk               (clk),
        .rst_n_i           (rst_n),
        .stall_i           (stall),
        .flush_i           (flush),
        .exception_flush_i (exc_flush),
        .in_valid_i        (drv.valid),
        .in_pc_i           (drv.pc),
        .in_rs_data_i      (drv.rs),
        .in_rt_data_i      (drv.rt),
        .in_ext_imm_i      (drv.imm),
        .in_sa_i           (drv.sa),
        .in_j_idx_i        (drv.jidx),
        .in_alu_op_i       (drv.op),
        .in_src_b_i        (drv.srcb),
        .in_check_ov_i     (drv.chk),
        .in_br_cond_i      (drv.br),
        .in_link_i         (drv.link),
        .in_wr_en_i        (drv.wr_en),
        .in_wr_dst_i       (drv.dst),
        .out_valid_o       (out_valid),
        .out_wr_en_o       (out_wr_en),
        .out_wr_dst_o      (out_wr_dst),
        .out_result_o      (out_result),
        .redirect_o        (redirect),
        .redirect_target_o (redirect_target),
        .exc_ov_o          (exc_ov)
    );

    // ****************************************
    // Random numbers
    // ****************************************

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // Taps 16, 14, 13, 11
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // ****************************************
    // Reference model
    // ****************************************

    function automatic word_t calc_alu(input instr_t i);
        word_t b;
        b = (i.srcb == SRC_B_IMM) ? i.imm : i.rt;
        case (i.op)
            ALU_ADD:  return i.rs + b;
            ALU_SUB:  return i.rs - b;
            ALU_AND:  return i.rs & b;
            ALU_OR:   return i.rs | b;
            ALU_XOR:  return i.rs ^ b;
            ALU_NOR:  return ~(i.rs | b);
            ALU_SLT:  return ($signed(i.rs) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (i.rs < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return i.rt << i.sa;
            ALU_SRL:  return i.rt >> i.sa;
            ALU_SRA:  return word_t'($signed(i.rt) >>> i.sa);
            ALU_LUI:  return {i.imm[15:0], 16'h0000};
            default:  return '0;
        endcase
    endfunction

    function automatic logic calc_ov(input instr_t i);
        logic [32:0] wide;
        word_t       b;
        b = (i.srcb == SRC_B_IMM) ? i.imm : i.rt;
        if (i.op == ALU_ADD) begin
            wide = {i.rs[31], i.rs} + {b[31], b};
        end else if (i.op == ALU_SUB) begin
            wide = {i.rs[31], i.rs} - {b[31], b};
        end else begin
            return 1'b0;
        end
        return wide[32] != wide[31]; // Sign-extended result does not fit 32 bits
    endfunction

    function automatic logic calc_taken(input instr_t i);
        logic t;
        case (i.br)
            BR_BEQ:       t = (i.rs == i.rt);
            BR_BNE:       t = (i.rs != i.rt);
            BR_BLEZ:      t = ($signed(i.rs) <= 0);
            BR_BGTZ:      t = ($signed(i.rs) > 0);
            BR_BLTZ:      t = ($signed(i.rs) < 0);
            BR_BGEZ:      t = ($signed(i.rs) >= 0);
            BR_J, BR_JR:  t = 1'b1;
            default:      t = 1'b0;
        endcase
        return t && i.valid;
    endfunction

    function automatic word_t calc_target(input instr_t i);
        word_t next_pc;
        next_pc = i.pc + 32'd4;
        case (i.br)
            BR_J:    return {next_pc[31:28], i.jidx, 2'b00};
            BR_JR:   return i.rs;
            default: return next_pc + (i.imm << 2);
        endcase
    endfunction

    // Old stage 1 feeds stage 2 before stage 1 loads the new inputs
    task automatic update_model();
        word_t alu_res;
        logic  ov_trap;
        alu_res = calc_alu(s1);
        ov_trap = s1.valid && s1.chk && calc_ov(s1);
        if (exc_flush) begin
            exp_valid    = 1'b0;
            exp_wr_en    = 1'b0;
            exp_redirect = 1'b0;
            exp_exc      = 1'b0;
        end else if (!stall) begin
            exp_valid    = s1.valid;
            exp_wr_en    = s1.valid && s1.wr_en && !ov_trap;
            exp_redirect = calc_taken(s1);
            exp_exc      = ov_trap;
        end
        if (!stall) begin
            exp_dst    = s1.dst;
            exp_result = s1.link ? s1.pc + 32'd8 : alu_res;
            exp_target = calc_target(s1);
        end
        if (exc_flush || (flush && !stall)) begin
            s1 = '0;
        end else if (!stall) begin
            s1 = drv;
        end
    endtask

    // ****************************************
    // Checks and sequencing
    // ****************************************

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_value("out_valid_o", 32'(out_valid), 32'(exp_valid));
        check_value("out_wr_en_o", 32'(out_wr_en), 32'(exp_wr_en));
        check_value("redirect_o", 32'(redirect), 32'(exp_redirect));
        check_value("exc_ov_o", 32'(exc_ov), 32'(exp_exc));
        if (exp_valid) begin
            check_value("out_wr_dst_o", 32'(out_wr_dst), 32'(exp_dst));
            check_value("out_result_o", out_result, exp_result);
        end
        if (exp_redirect) begin
            check_value("redirect_target_o", redirect_target, exp_target);
        end
    endtask

    task automatic cycle();
        @(posedge clk);
        if (drv.valid && !stall && !flush && !exc_flush) begin
            issued++;
        end
        update_model();
        edge_stall = stall;
        @(negedge clk);
        if (!edge_stall && out_valid) begin
            retired++;
        end
        check_outputs();
    endtask

    task automatic set_idle();
        drv       = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        exc_flush = 1'b0;
    endtask

    // Kind 0 ALU only, 1 branches, 2 overflow operands, 3 anything
    task automatic gen_instr(input int kind);
        drv.valid = 1'b1;
        drv.pc    = rand_bits(30) << 2;
        drv.rs    = rand_bits(32);
        drv.rt    = rand_bits(32);
        drv.imm   = rand_bits(32);
        drv.sa    = shamt_t'(rand_bits(5));
        drv.jidx  = jidx_t'(rand_bits(26));
        drv.op    = alu_op_e'(4'(rand_bits(4) % 32'd12));
        drv.srcb  = (rand_bits(1) != 0) ? SRC_B_IMM : SRC_B_RT;
        drv.chk   = 1'b0;
        drv.br    = BR_NONE;
        drv.link  = 1'b0;
        drv.wr_en = (rand_bits(3) != 0);
        drv.dst   = reg_addr_t'(rand_bits(5));
        if (kind == 1 || kind == 3) begin
            drv.br   = br_cond_e'(4'(rand_bits(4) % 32'd9));
            drv.link = (rand_bits(1) != 0);
            if (rand_bits(2) == 0) begin
                drv.rt = drv.rs; // Lets BEQ and BNE see equal operands
            end
            if (rand_bits(3) == 0) begin
                drv.rs = '0;
            end
            if (rand_bits(3) == 0) begin
                drv.pc = {4'(rand_bits(4)), 28'hFFFFFFC}; // Last word of a 256 MB region
            end
        end
        if (kind == 3) begin
            drv.chk   = (rand_bits(1) != 0);
            drv.valid = (rand_bits(3) != 0); // Bubbles that still carry fields
        end
        if (kind == 2) begin
            drv.srcb  = SRC_B_RT;
            drv.chk   = (rand_bits(1) != 0);
            drv.wr_en = 1'b1;
            if (rand_bits(1) != 0) begin
                drv.op = ALU_ADD; // Two large positives
                drv.rs = {2'b01, 30'(rand_bits(30))};
                drv.rt = {2'b01, 30'(rand_bits(30))};
            end else begin
                drv.op = ALU_SUB; // Large negative minus large positive
                drv.rs = {2'b10, 30'(rand_bits(30))};
                drv.rt = {2'b01, 30'(rand_bits(30))};
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests_run, name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic run_random(input int kind, input int n_cyc);
        repeat (n_cyc) begin
            gen_instr(kind);
            cycle();
        end
        set_idle();
        repeat (DRAIN_CYC) cycle();
    endtask

    task automatic test_stall();
        issued  = 0;
        retired = 0;
        repeat (T5_CYC) begin
            if (!stall) begin
                gen_instr(3); // A held instruction stays on the inputs
            end
            stall = (rand_bits(2) == 0);
            cycle();
        end
        set_idle();
        repeat (DRAIN_CYC) cycle();
        if (issued != retired) begin
            errors++;
            test_errs++;
            $display("Stall test lost or duplicated work: %0d issued, %0d retired",
                     issued, retired);
        end
        finish_test("stall");
    endtask

    task automatic test_flush();
        repeat (T6_CYC) begin
            gen_instr(3);
            stall     = (rand_bits(2) == 0);
            flush     = (rand_bits(2) == 0);
            exc_flush = (rand_bits(3) == 0);
            cycle();
        end
        set_idle();
        repeat (DRAIN_CYC) cycle();
        finish_test("flush");
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        lfsr         = 16'd52590;
        errors       = 0;
        checks       = 0;
        test_errs    = 0;
        tests_run    = 0;
        cycle_cnt    = 0;
        s1           = '0;
        exp_valid    = 1'b0;
        exp_wr_en    = 1'b0;
        exp_redirect = 1'b0;
        exp_exc      = 1'b0;
        exp_dst      = '0;
        exp_result   = '0;
        exp_target   = '0;
        set_idle();
        wait (rst_n == 1'b1);

        check_outputs();
        repeat (T1_CYC) cycle();
        finish_test("reset");

        run_random(0, T2_CYC);
        finish_test("alu ops");
        run_random(1, T3_CYC);
        finish_test("branches");
        run_random(2, T4_CYC);
        finish_test("overflow");
        test_stall();
        test_flush();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/ex_types_pkg.sv
common/ex_ctrl_pkg.sv
common/id_ex_if.sv
verilog/id_ex_reg.sv
alu/ex_alu.sv
branch/ex_branch_unit.sv
verilog/ex_result_merge.sv
verilog/ex_stage_top.sv
verif/tb_clkgen.sv
verif/tb_ex_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_ex_stage \
    && ./obj_dir/Vtb_ex_stage | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }

grep -q "^Done: no errors$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
